//--- src/gl_pkg.sv
`default_nettype none

package gl_pkg;

    //////////////////////////////
    // widths
    localparam int WORD_W     = 32;      // wishbone data
    localparam int FIX_W      = 16;      // q8.8 value
    localparam int FRAC_W     = 8;
    localparam int COLOR_W    = 23;
    localparam int ADR_W      = 6;       // word address
    localparam int LANES      = 4;       // one lane per matrix row
    localparam int ROW_W      = LANES * FIX_W;
    localparam int CMDQ_DEPTH = 4;
    localparam int CMDQ_PTR_W = $clog2(CMDQ_DEPTH);
    localparam int CMDQ_CNT_W = $clog2(CMDQ_DEPTH + 1);

    //////////////////////////////
    // opcodes, anything else is dropped by dispatch
    localparam logic [7:0] OP_DRAW  = 8'h01;
    localparam logic [7:0] OP_FLUSH = 8'h02;

    //////////////////////////////
    // word address map
    localparam logic [ADR_W-1:0] ADR_MAT   = 6'h00;   // 0x00..0x0f, row-major
    localparam logic [ADR_W-1:0] ADR_VP_X  = 6'h10;
    localparam logic [ADR_W-1:0] ADR_VP_Y  = 6'h11;
    localparam logic [ADR_W-1:0] ADR_VP_HW = 6'h12;   // half width
    localparam logic [ADR_W-1:0] ADR_VP_HH = 6'h13;   // half height
    localparam logic [ADR_W-1:0] ADR_CMD   = 6'h20;   // push on write, fill count on read

    typedef logic signed [FIX_W-1:0] fix_t;

    localparam fix_t MARKER_VAL = '1;

    // command view of a queue word
    typedef struct packed {
        logic                is_cmd;
        logic [COLOR_W-1:0]  imm;
        logic [7:0]          opcode;
    } gl_cmd_t;

    // data view, one vertex component
    typedef struct packed {
        logic                is_cmd;
        logic [14:0]         pad;
        fix_t                value;
    } gl_data_t;

    typedef union packed {
        gl_cmd_t  cmd;
        gl_data_t data;
    } gl_word_u;

endpackage

`default_nettype wire

//--- src/gl_vtx_if.sv
`timescale 1ns/1ps
`default_nettype none

// one issued vertex or end-of-list marker
interface gl_vtx_if;

    logic                       valid;
    gl_pkg::fix_t               vx;
    gl_pkg::fix_t               vy;
    gl_pkg::fix_t               vz;
    gl_pkg::fix_t               vw;
    logic [gl_pkg::COLOR_W-1:0] color;
    logic                       marker;   // flush, no geometry

    modport src (output valid, vx, vy, vz, vw, color, marker);
    modport dst (input  valid, vx, vy, vz, vw, color, marker);

endinterface

`default_nettype wire

//--- src/gl_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gl_host_regs (
    input  logic                                          clk1,
    input  logic                                          arst_n,
    input  logic                                          wb_cyc,
    input  logic                                          wb_stb,
    input  logic                                          wb_we,
    input  logic [gl_pkg::ADR_W-1:0]                      wb_adr,
    input  logic [gl_pkg::WORD_W-1:0]                     wb_dat_w,
    output logic [gl_pkg::WORD_W-1:0]                     wb_dat_r,
    output logic                                          wb_ack,
    output gl_pkg::gl_word_u                              cmd_word,
    output logic                                          cmd_avail,
    input  logic                                          cmd_pop,
    output logic [gl_pkg::LANES-1:0][gl_pkg::ROW_W-1:0]   mat_row,
    output gl_pkg::fix_t                                  vp_x,
    output gl_pkg::fix_t                                  vp_y,
    output gl_pkg::fix_t                                  vp_hw,
    output gl_pkg::fix_t                                  vp_hh
);

    gl_pkg::fix_t                   mat [gl_pkg::LANES*gl_pkg::LANES];
    gl_pkg::gl_word_u               cmdq [gl_pkg::CMDQ_DEPTH];
    logic [gl_pkg::CMDQ_PTR_W-1:0]  wr_ptr;
    logic [gl_pkg::CMDQ_PTR_W-1:0]  rd_ptr;
    logic [gl_pkg::CMDQ_CNT_W-1:0]  cmd_cnt;
    logic                           req;
    logic                           is_mat;
    logic                           cmd_wr;
    logic                           cmdq_full;
    logic                           accept;
    logic                           push;
    logic [gl_pkg::WORD_W-1:0]      rd_data;

    function automatic logic [gl_pkg::WORD_W-1:0] sext(input gl_pkg::fix_t v);
        return {{(gl_pkg::WORD_W-gl_pkg::FIX_W){v[gl_pkg::FIX_W-1]}}, v};
    endfunction

    //////////////////////////////
    // wishbone decode
    assign req       = wb_cyc && wb_stb;
    assign is_mat    = wb_adr[gl_pkg::ADR_W-1:4] == gl_pkg::ADR_MAT[gl_pkg::ADR_W-1:4];
    assign cmd_wr    = wb_we && (wb_adr == gl_pkg::ADR_CMD);
    assign cmdq_full = cmd_cnt == gl_pkg::CMDQ_CNT_W'(gl_pkg::CMDQ_DEPTH);
    assign accept    = req && !wb_ack && !(cmd_wr && cmdq_full);   // full queue stalls host
    assign push      = accept && cmd_wr;

    always_comb
    begin
        rd_data = '0;   // unmapped reads zero
        if (is_mat)
            rd_data = sext(mat[wb_adr[3:0]]);
        else
        begin
            case (wb_adr)
                gl_pkg::ADR_VP_X:  rd_data = sext(vp_x);
                gl_pkg::ADR_VP_Y:  rd_data = sext(vp_y);
                gl_pkg::ADR_VP_HW: rd_data = sext(vp_hw);
                gl_pkg::ADR_VP_HH: rd_data = sext(vp_hh);
                gl_pkg::ADR_CMD:   rd_data = gl_pkg::WORD_W'(cmd_cnt);
                default:           rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            vp_x     <= '0;
            vp_y     <= '0;
            vp_hw    <= '0;
            vp_hh    <= '0;
            for (int i = 0; i < gl_pkg::LANES*gl_pkg::LANES; i++)
                mat[i] <= '0;
        end
        else
        begin
            wb_ack <= accept;   // single cycle, never back to back
            if (accept)
            begin
                wb_dat_r <= rd_data;
                if (wb_we && is_mat)
                    mat[wb_adr[3:0]] <= wb_dat_w[gl_pkg::FIX_W-1:0];
                else if (wb_we)
                begin
                    case (wb_adr)
                        gl_pkg::ADR_VP_X:  vp_x  <= wb_dat_w[gl_pkg::FIX_W-1:0];
                        gl_pkg::ADR_VP_Y:  vp_y  <= wb_dat_w[gl_pkg::FIX_W-1:0];
                        gl_pkg::ADR_VP_HW: vp_hw <= wb_dat_w[gl_pkg::FIX_W-1:0];
                        gl_pkg::ADR_VP_HH: vp_hh <= wb_dat_w[gl_pkg::FIX_W-1:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // column c of each row sits in the low bits first
    always_comb
    begin
        for (int r = 0; r < gl_pkg::LANES; r++)
            for (int c = 0; c < gl_pkg::LANES; c++)
                mat_row[r][c*gl_pkg::FIX_W +: gl_pkg::FIX_W] = mat[r*gl_pkg::LANES + c];
    end

    //////////////////////////////
    // command queue
    always_ff @(posedge clk1)
    begin
        if (push)
            cmdq[wr_ptr] <= wb_dat_w;
    end

    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            cmd_cnt <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (cmd_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, cmd_pop})
                2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
                2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
                default: cmd_cnt <= cmd_cnt;   // both or neither
            endcase
        end
    end

    assign cmd_word  = cmdq[rd_ptr];
    assign cmd_avail = cmd_cnt != '0;

endmodule

`default_nettype wire

//--- src/gl_vertex_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module gl_vertex_dispatch (
    input  logic             clk1,
    input  logic             arst_n,
    input  gl_pkg::gl_word_u cmd_word,
    input  logic             cmd_avail,
    input  logic             adv,
    output logic             cmd_pop,
    gl_vtx_if.src            vtx
);

    logic is_data;
    logic is_draw;
    logic is_flush;

    assign cmd_pop  = cmd_avail && adv;   // one word per enabled cycle
    assign is_data  = !cmd_word.data.is_cmd;
    assign is_draw  = cmd_word.cmd.is_cmd && (cmd_word.cmd.opcode == gl_pkg::OP_DRAW);
    assign is_flush = cmd_word.cmd.is_cmd && (cmd_word.cmd.opcode == gl_pkg::OP_FLUSH);

    //////////////////////////////
    // component shift register and issue stage
    // the component registers drive the bus directly; they only
    // change on a pop, which is the same edge the lanes sample on
    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vtx.vx     <= '0;
            vtx.vy     <= '0;
            vtx.vz     <= '0;
            vtx.vw     <= '0;
            vtx.valid  <= 1'b0;
            vtx.marker <= 1'b0;
        end
        else
        begin
            if (cmd_pop && is_data)
            begin
                vtx.vx <= vtx.vy;   // oldest drops out
                vtx.vy <= vtx.vz;
                vtx.vz <= vtx.vw;
                vtx.vw <= cmd_word.data.value;
            end
            if (adv)
            begin
                vtx.valid  <= cmd_pop && (is_draw || is_flush);   // unknown ops vanish
                vtx.marker <= cmd_pop && is_flush;
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        if (cmd_pop && is_draw)
            vtx.color <= cmd_word.cmd.imm;
    end

endmodule

`default_nettype wire

//--- src/gl_dot_lane.sv
`timescale 1ns/1ps
`default_nettype none

module gl_dot_lane (
    input  logic                     clk1,
    input  logic                     arst_n,
    input  logic                     adv,
    input  logic [gl_pkg::ROW_W-1:0] row,
    gl_vtx_if.dst                    vtx,
    output logic                     res_valid,
    output gl_pkg::fix_t             res
);

    gl_pkg::fix_t                     comp [gl_pkg::LANES];
    logic signed [2*gl_pkg::FIX_W-1:0] prod [gl_pkg::LANES];
    logic signed [2*gl_pkg::FIX_W-1:0] sum;
    logic                             prod_valid;

    assign comp[0] = vtx.vx;
    assign comp[1] = vtx.vy;
    assign comp[2] = vtx.vz;
    assign comp[3] = vtx.vw;

    //////////////////////////////
    // stage 1: products, q16.16
    always_ff @(posedge clk1)
    begin
        if (adv)
            for (int c = 0; c < gl_pkg::LANES; c++)
                prod[c] <= $signed(row[c*gl_pkg::FIX_W +: gl_pkg::FIX_W]) * comp[c];
    end

    assign sum = prod[0] + prod[1] + prod[2] + prod[3];   // wraps, low bits exact

    //////////////////////////////
    // stage 2: back to q8.8
    always_ff @(posedge clk1)
    begin
        if (adv)
            res <= sum[gl_pkg::FRAC_W +: gl_pkg::FIX_W];
    end

    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prod_valid <= 1'b0;
            res_valid  <= 1'b0;
        end
        else if (adv)
        begin
            prod_valid <= vtx.valid;
            res_valid  <= prod_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/gl_viewport_pack.sv
`timescale 1ns/1ps
`default_nettype none

module gl_viewport_pack (
    input  logic                       clk1,
    input  logic                       arst_n,
    gl_vtx_if.dst                      vtx,
    input  logic [gl_pkg::LANES-1:0]   res_valid,
    input  gl_pkg::fix_t               res [gl_pkg::LANES],
    input  gl_pkg::fix_t               vp_x,
    input  gl_pkg::fix_t               vp_y,
    input  gl_pkg::fix_t               vp_hw,
    input  gl_pkg::fix_t               vp_hh,
    input  logic                       out_ready,
    output logic                       adv,
    output logic                       out_valid,
    output gl_pkg::fix_t               out_x,
    output gl_pkg::fix_t               out_y,
    output gl_pkg::fix_t               out_z,
    output gl_pkg::fix_t               out_w,
    output logic [gl_pkg::COLOR_W-1:0] out_color,
    output logic                       out_marker
);

    logic [gl_pkg::COLOR_W-1:0]        color_d [2];
    logic                              marker_d [2];
    logic signed [2*gl_pkg::FIX_W-1:0] scale_x;
    logic signed [2*gl_pkg::FIX_W-1:0] scale_y;
    gl_pkg::fix_t                      scr_x;
    gl_pkg::fix_t                      scr_y;
    logic                              res_ok;

    // whole pipeline stalls while the output word is held
    assign adv    = !out_valid || out_ready;
    assign res_ok = &res_valid;   // lanes run in lockstep

    //////////////////////////////
    // side data, two stages like the lanes
    always_ff @(posedge clk1)
    begin
        if (adv)
        begin
            color_d[0]  <= vtx.color;
            marker_d[0] <= vtx.marker;
            color_d[1]  <= color_d[0];
            marker_d[1] <= marker_d[0];
        end
    end

    //////////////////////////////
    // viewport map, 16-bit wrap
    assign scale_x = res[0] * vp_hw;
    assign scale_y = res[1] * vp_hh;
    assign scr_x   = vp_x + vp_hw + scale_x[gl_pkg::FRAC_W +: gl_pkg::FIX_W];
    assign scr_y   = vp_y + vp_hh + scale_y[gl_pkg::FRAC_W +: gl_pkg::FIX_W];

    always_ff @(posedge clk1 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid  <= 1'b0;
            out_x      <= '0;
            out_y      <= '0;
            out_z      <= '0;
            out_w      <= '0;
            out_color  <= '0;
            out_marker <= 1'b0;
        end
        else if (adv)
        begin
            out_valid <= res_ok;
            if (res_ok)
            begin
                out_marker <= marker_d[1];
                if (marker_d[1])
                begin
                    out_x     <= gl_pkg::MARKER_VAL;   // end of list
                    out_y     <= gl_pkg::MARKER_VAL;
                    out_z     <= gl_pkg::MARKER_VAL;
                    out_w     <= gl_pkg::MARKER_VAL;
                    out_color <= '0;
                end
                else
                begin
                    out_x     <= scr_x;
                    out_y     <= scr_y;
                    out_z     <= res[2];   // clip z, no divide
                    out_w     <= res[3];
                    out_color <= color_d[1];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/gl_xform_top.sv
`timescale 1ns/1ps
`default_nettype none

module gl_xform_top (
    input  logic                       clk1,
    input  logic                       arst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [gl_pkg::ADR_W-1:0]   wb_adr,
    input  logic [gl_pkg::WORD_W-1:0]  wb_dat_w,
    output logic [gl_pkg::WORD_W-1:0]  wb_dat_r,
    output logic                       wb_ack,
    output logic                       out_valid,
    input  logic                       out_ready,
    output gl_pkg::fix_t               out_x,
    output gl_pkg::fix_t               out_y,
    output gl_pkg::fix_t               out_z,
    output gl_pkg::fix_t               out_w,
    output logic [gl_pkg::COLOR_W-1:0] out_color,
    output logic                       out_marker
);

    gl_pkg::gl_word_u                            cmd_word;
    logic                                        cmd_avail;
    logic                                        cmd_pop;
    logic                                        adv;
    logic [gl_pkg::LANES-1:0][gl_pkg::ROW_W-1:0] mat_row;
    gl_pkg::fix_t                                vp_x;
    gl_pkg::fix_t                                vp_y;
    gl_pkg::fix_t                                vp_hw;
    gl_pkg::fix_t                                vp_hh;
    logic [gl_pkg::LANES-1:0]                    res_valid;
    gl_pkg::fix_t                                res [gl_pkg::LANES];

    gl_vtx_if vtx_bus ();

    gl_host_regs u_regs (
        .clk1      (clk1),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .cmd_word  (cmd_word),
        .cmd_avail (cmd_avail),
        .cmd_pop   (cmd_pop),
        .mat_row   (mat_row),
        .vp_x      (vp_x),
        .vp_y      (vp_y),
        .vp_hw     (vp_hw),
        .vp_hh     (vp_hh)
    );

    gl_vertex_dispatch u_dispatch (
        .clk1      (clk1),
        .arst_n    (arst_n),
        .cmd_word  (cmd_word),
        .cmd_avail (cmd_avail),
        .adv       (adv),
        .cmd_pop   (cmd_pop),
        .vtx       (vtx_bus)
    );

    //////////////////////////////
    // one lane per matrix row
    for (genvar i = 0; i < gl_pkg::LANES; i++)
    begin : g_lane
        gl_dot_lane u_lane (
            .clk1      (clk1),
            .arst_n    (arst_n),
            .adv       (adv),
            .row       (mat_row[i]),
            .vtx       (vtx_bus),
            .res_valid (res_valid[i]),
            .res       (res[i])
        );
    end

    gl_viewport_pack u_pack (
        .clk1       (clk1),
        .arst_n     (arst_n),
        .vtx        (vtx_bus),
        .res_valid  (res_valid),
        .res        (res),
        .vp_x       (vp_x),
        .vp_y       (vp_y),
        .vp_hw      (vp_hw),
        .vp_hh      (vp_hh),
        .out_ready  (out_ready),
        .adv        (adv),          // global stall source
        .out_valid  (out_valid),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_z      (out_z),
        .out_w      (out_w),
        .out_color  (out_color),
        .out_marker (out_marker)
    );

endmodule

`default_nettype wire

//--- verif/gl_xform_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gl_xform_checker (
    input logic                       clk1,
    input logic                       arst_n,
    input logic                       wb_cyc,
    input logic                       wb_stb,
    input logic                       wb_ack,
    input logic [gl_pkg::WORD_W-1:0]  wb_dat_r,
    input logic                       out_valid,
    input logic                       out_ready,
    input gl_pkg::fix_t               out_x,
    input gl_pkg::fix_t               out_y,
    input gl_pkg::fix_t               out_z,
    input gl_pkg::fix_t               out_w,
    input logic [gl_pkg::COLOR_W-1:0] out_color,
    input logic                       out_marker
);

    //////////////////////////////
    // wishbone slave
    ack_pulse: assert property (@(posedge clk1) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for more than one cycle");

    ack_in_cycle: assert property (@(posedge clk1) disable iff (!arst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside a bus cycle");

    //////////////////////////////
    // output stream
    out_hold: assert property (@(posedge clk1) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable({out_x, out_y, out_z, out_w,
            out_color, out_marker})))
        else $error("output changed while stalled");

    out_known: assert property (@(posedge clk1) disable iff (!arst_n)
        !$isunknown({wb_ack, wb_dat_r, out_valid, out_x, out_y, out_z, out_w,
            out_color, out_marker}))
        else $error("unknown value on a DUT output");

endmodule

`default_nettype wire

//--- verif/gl_xform_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gl_xform_tb;

    typedef struct packed {
        gl_pkg::fix_t               x;
        gl_pkg::fix_t               y;
        gl_pkg::fix_t               z;
        gl_pkg::fix_t               w;
        logic [gl_pkg::COLOR_W-1:0] color;
        logic                       marker;
    } out_rec_t;

    localparam int N_OPS      = 400;   // bus accesses over all tests
    localparam int CYC_PER_OP = 16;    // random ready plus full queue waits
    localparam int STALL_LEN  = 80;
    localparam int MAX_CYCLES = N_OPS * CYC_PER_OP + STALL_LEN;

    logic                       clk1 = 1'b0;
    logic                       arst_n;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [gl_pkg::ADR_W-1:0]   wb_adr;
    logic [gl_pkg::WORD_W-1:0]  wb_dat_w;
    logic [gl_pkg::WORD_W-1:0]  wb_dat_r;
    logic                       wb_ack;
    logic                       out_valid;
    logic                       out_ready;
    gl_pkg::fix_t               out_x;
    gl_pkg::fix_t               out_y;
    gl_pkg::fix_t               out_z;
    gl_pkg::fix_t               out_w;
    logic [gl_pkg::COLOR_W-1:0] out_color;
    logic                       out_marker;

    integer       seed;
    logic [31:0]  rnd;
    logic [31:0]  rdy_rnd;
    int           cycle_cnt = 0;
    int           stall_until = 0;
    logic         ready_rand = 1'b0;
    int           errors = 0;
    int           checks = 0;
    int           n_tests = 0;
    int           n_failed = 0;
    int           test_err0;
    string        test_name;
    int           max_wait;
    logic [31:0]  rd;
    out_rec_t     got_exp;
    out_rec_t     exp_q [$];
    gl_pkg::fix_t mat_m [16];   // row-major like the address map
    gl_pkg::fix_t vp_m [4];     // x, y, hw, hh
    gl_pkg::fix_t comp_m [4];   // last four data words with the oldest first

    always #50 clk1 = ~clk1;

    gl_xform_top UUT (
        .clk1       (clk1),
        .arst_n     (arst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_z      (out_z),
        .out_w      (out_w),
        .out_color  (out_color),
        .out_marker (out_marker)
    );

    bind gl_xform_top gl_xform_checker u_checker (.*);

    always @(posedge clk1)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(negedge clk1)
    begin
        rdy_rnd = $random(seed);   // next ready draw
    end

    always @(posedge clk1)
    begin
        if (cycle_cnt < stall_until)
            out_ready <= 1'b0;   // long stall
        else if (ready_rand)
            out_ready <= rdy_rnd[0];
        else
            out_ready <= 1'b1;
    end

    //////////////////////////////
    // compare tasks
    task automatic check_word(input string name, input logic [gl_pkg::WORD_W-1:0] got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_fix(input string name, input gl_pkg::fix_t got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input logic [gl_pkg::COLOR_W-1:0] got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // each transfer is taken at the following rising edge
    always @(negedge clk1)
    begin
        if (arst_n && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("an output appeared with no vertex pending");
            end
            else
            begin
                got_exp = exp_q.pop_front();
                check_flag("out_marker", out_marker, got_exp.marker);
                check_fix("out_x", out_x, got_exp.x);
                check_fix("out_y", out_y, got_exp.y);
                check_fix("out_z", out_z, got_exp.z);
                check_fix("out_w", out_w, got_exp.w);
                check_color("out_color", out_color, got_exp.color);
            end
        end
    end

    //////////////////////////////
    // reference model in signed q8.8
    function automatic gl_pkg::fix_t lane_model(input int r);
        logic signed [31:0] acc;
        logic signed [31:0] a;
        logic signed [31:0] b;
        acc = 0;
        for (int c = 0; c < 4; c++)
        begin
            a = mat_m[r*4 + c];
            b = comp_m[c];
            acc = acc + a * b;   // wraps at 32 bits
        end
        return acc[gl_pkg::FRAC_W +: gl_pkg::FIX_W];
    endfunction

    function automatic gl_pkg::fix_t screen_coord(input gl_pkg::fix_t org, half, lane);
        logic signed [31:0] h;
        logic signed [31:0] l;
        logic signed [31:0] s;
        h = half;
        l = lane;
        s = h * l;
        return org + half + s[gl_pkg::FRAC_W +: gl_pkg::FIX_W];
    endfunction

    //////////////////////////////
    // bus driver
    task automatic wb_access(input logic we, input logic [gl_pkg::ADR_W-1:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdat,
                             output int waits);
        waits = 0;
        @(posedge clk1);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do
        begin
            @(negedge clk1);
            waits++;
        end
        while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge clk1);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [gl_pkg::ADR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        int          w;
        wb_access(1'b1, adr, dat, unused, w);
        if (w > max_wait)
            max_wait = w;
    endtask

    task automatic read_reg(input logic [gl_pkg::ADR_W-1:0] adr, output logic [31:0] dat);
        int w;
        wb_access(1'b0, adr, 32'h0, dat, w);
    endtask

    task automatic push_data(input gl_pkg::fix_t v);
        write_reg(gl_pkg::ADR_CMD, {1'b0, 15'h0, v});
        comp_m[0] = comp_m[1];
        comp_m[1] = comp_m[2];
        comp_m[2] = comp_m[3];
        comp_m[3] = v;
    endtask

    task automatic push_draw(input logic [gl_pkg::COLOR_W-1:0] color);
        out_rec_t e;
        write_reg(gl_pkg::ADR_CMD, {1'b1, color, gl_pkg::OP_DRAW});
        e.x      = screen_coord(vp_m[0], vp_m[2], lane_model(0));
        e.y      = screen_coord(vp_m[1], vp_m[3], lane_model(1));
        e.z      = lane_model(2);
        e.w      = lane_model(3);
        e.color  = color;
        e.marker = 1'b0;
        exp_q.push_back(e);
    endtask

    task automatic push_flush();
        out_rec_t e;
        write_reg(gl_pkg::ADR_CMD, {1'b1, 23'h0, gl_pkg::OP_FLUSH});
        e = {{4{16'hffff}}, 23'h0, 1'b1};   // marker fields all ones and color zero
        exp_q.push_back(e);
    endtask

    task automatic send_vertex();
        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            push_data(rnd[15:0]);
        end
        rnd = $random(seed);
        push_draw(rnd[22:0]);
    endtask

    task automatic drain_outputs();
        while (exp_q.size() != 0)
            @(negedge clk1);
        repeat (6) @(negedge clk1);   // catch stray outputs
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (errors != test_err0)
            n_failed++;
        $display("%-14s %s", test_name, (errors == test_err0) ? "passed" : "FAILED");
    endtask

    initial
    begin
        logic signed [31:0] ext;
        seed     = 32'h6bb;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        out_ready = 1'b1;
        max_wait = 0;
        for (int i = 0; i < 4; i++)
            comp_m[i] = '0;
        repeat (3) @(posedge clk1);
        arst_n <= 1'b1;

        start_test("reset");
        @(negedge clk1);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("wb_ack", wb_ack, 1'b0);
        read_reg(gl_pkg::ADR_CMD, rd);
        check_word("wb_dat_r", rd, 32'h0);
        end_test();

        start_test("readback");
        for (int i = 0; i < 16; i++)
        begin
            rnd = $random(seed);
            mat_m[i] = rnd[15:0];
            write_reg(gl_pkg::ADR_MAT + 6'(i), rnd);
        end
        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            vp_m[i] = rnd[15:0];
            write_reg(gl_pkg::ADR_VP_X + 6'(i), rnd);
        end
        for (int i = 0; i < 16; i++)
        begin
            read_reg(gl_pkg::ADR_MAT + 6'(i), rd);
            ext = mat_m[i];
            check_word("wb_dat_r", rd, ext);
        end
        for (int i = 0; i < 4; i++)
        begin
            read_reg(gl_pkg::ADR_VP_X + 6'(i), rd);
            ext = vp_m[i];
            check_word("wb_dat_r", rd, ext);
        end
        write_reg(6'h14, 32'hffff_ffff);   // unmapped so the write is dropped
        read_reg(6'h14, rd);
        check_word("wb_dat_r", rd, 32'h0);
        read_reg(6'h21, rd);
        check_word("wb_dat_r", rd, 32'h0);
        read_reg(6'h3f, rd);
        check_word("wb_dat_r", rd, 32'h0);
        end_test();

        start_test("transform");
        repeat (40) send_vertex();
        drain_outputs();
        end_test();

        start_test("backpressure");
        @(posedge clk1);
        ready_rand <= 1'b1;
        repeat (20) send_vertex();
        drain_outputs();
        @(posedge clk1);
        ready_rand  <= 1'b0;
        stall_until <= cycle_cnt + STALL_LEN;
        max_wait = 0;
        repeat (6) send_vertex();
        drain_outputs();
        if (max_wait < 20)
        begin
            errors++;
            $display("no command write was held off during the long stall");
        end
        end_test();

        start_test("flush_opcodes");
        push_flush();
        rnd = $random(seed);
        push_data(rnd[15:0]);
        rnd = $random(seed);
        push_data(rnd[31:16]);
        push_draw(23'h5a5a5);   // two old components stay in use
        write_reg(gl_pkg::ADR_CMD, {1'b1, 23'h12345, 8'h7f});
        write_reg(gl_pkg::ADR_CMD, {1'b1, 23'h0, 8'h00});
        push_draw(23'h7fffff);
        push_flush();
        drain_outputs();
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/gl_pkg.sv
src/gl_vtx_if.sv
src/gl_host_regs.sv
src/gl_vertex_dispatch.sv
src/gl_dot_lane.sv
src/gl_viewport_pack.sv
src/gl_xform_top.sv
verif/gl_xform_checker.sv
verif/gl_xform_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
verilator --binary --assert -Wno-fatal -f all.f --top-module gl_xform_tb \
    -o gl_xform_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/gl_xform_sim > sim.log 2>&1
grep -qx "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
